/* build.f */
rtl/sram_pkg.sv
rtl/bus_phase_timer.sv
rtl/bus_cycle_fsm.sv
rtl/sram_bridge.sv
rtl/sram_subsys_top.sv
test/sram_model.sv
test/sram_bridge_assert.sv
test/tb_sram_subsys.sv

/* Makefile */
# Verilator build and run for the SRAM subsystem testbench

SIM      := verilator
SIMFLAGS := --binary --timing --assert -j 0
TOP      := tb_sram_subsys
FILELIST := build.f
OBJDIR   := obj_dir
LOG      := sim.log
PASS_MSG := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the log decides pass or fail, not the exit status of the binary
run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

/* test/tb_sram_subsys.sv */
/*
 * testbench for the SRAM subsystem
 * clock, reset, directed test tasks, bus monitor with reference memory,
 * timeout and summary
 */

`timescale 1ns/1ps

module tb_sram_subsys;

	import sram_pkg::*;

	localparam int RANDOM_REQS = 64;
	// directed requests plus the random run
	localparam int TOTAL_REQS = 10 + RANDOM_REQS;
	localparam int MAX_CYCLES = 4 * TOTAL_REQS + 200;

	logic clk;
	logic rst_n;
	logic req_valid;
	host_req_t req;
	logic req_ready;
	logic resp_valid;
	logic [15:0] rdata;
	logic c1;
	logic c3;
	logic bhe_n;
	logic ble_n;
	logic we_n;
	logic oe_n;
	logic [SRAM_ADDR_BITS-1:0] sram_addr;
	logic [15:0] sram_wdata;
	logic [15:0] sram_rdata;

	int seed = 32'ha35afea4;
	int cycle = 0;
	int err_count = 0;
	int check_count = 0;
	int accepted = 0;
	int responses = 0;

	// expected data and accept cycle per request in flight
	logic [15:0] exp_q[$];
	int acc_q[$];
	int acc_hist[$];
	logic [15:0] ref_mem[int];
	host_req_t last_req = '0;
	logic have_req = 1'b0;
	logic [15:0] last_rdata = '0;
	logic [15:0] exp_word;
	int acc_cycle;
	// slot phase of the clock that ends at the next edge
	logic [1:0] slot_phase = 2'd3;

	sram_subsys_top sram_subsys_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.req(req),
		.req_ready(req_ready),
		.resp_valid(resp_valid),
		.rdata(rdata),
		.c1(c1),
		.c3(c3),
		.bhe_n(bhe_n),
		.ble_n(ble_n),
		.we_n(we_n),
		.oe_n(oe_n),
		.sram_addr(sram_addr),
		.sram_wdata(sram_wdata),
		.sram_rdata(sram_rdata)
	);

	sram_model sram_model_inst (
		.addr(sram_addr),
		.wdata(sram_wdata),
		.rdata(sram_rdata),
		.we_n(we_n),
		.oe_n(oe_n),
		.bhe_n(bhe_n),
		.ble_n(ble_n)
	);

	bind sram_bridge sram_bridge_assert sram_bridge_assert_inst (
		.clk(tb_sram_subsys.clk),
		.rst_n(tb_sram_subsys.rst_n),
		.cmd(cmd),
		.we_n(we_n),
		.oe_n(oe_n),
		.bhe_n(bhe_n),
		.ble_n(ble_n)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic bit in_range(input host_req_t r);
		return r.addr[23:22] == 2'b00;
	endfunction

	// bank index above the word offset
	function automatic logic [20:0] word_addr(input host_req_t r);
		return {r.addr[21:19], r.addr[18:1]};
	endfunction

	function automatic logic [15:0] ref_read(input logic [20:0] a);
		if (ref_mem.exists(int'(a)))
			return ref_mem[int'(a)];
		// power-up content of the SRAM model
		return a[15:0] ^ {11'h000, a[20:16]} ^ 16'h6b1d;
	endfunction

	function automatic void ref_write(input logic [20:0] a, input logic [15:0] d,
		input logic [1:0] be);
		logic [15:0] w;
		w = ref_read(a);
		if (be[1])
			w[15:8] = d[15:8];
		if (be[0])
			w[7:0] = d[7:0];
		ref_mem[int'(a)] = w;
	endfunction

	function automatic host_req_t make_req(input logic [1:0] hi, input logic [2:0] bank,
		input logic [17:0] offset, input logic we, input logic [1:0] be,
		input logic [15:0] data);
		host_req_t r;
		r.addr = {hi, bank, offset};
		r.wdata = data;
		r.we = we;
		r.be = be;
		return r;
	endfunction

	task automatic expect_equal(input logic [31:0] got, input logic [31:0] want,
		input string what);
		check_count++;
		assert (got === want) else begin
			err_count++;
			$display("error at %t: %s, got %0h expected %0h", $time, what, got, want);
		end
	endtask

	task automatic report_and_finish();
		$display("checks %0d errors %0d accepted %0d responses %0d",
			check_count, err_count, accepted, responses);
		if (err_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	endtask

	// predicted response for each accepted request
	task automatic accept_request(input host_req_t r);
		logic [15:0] word;
		accepted++;
		acc_q.push_back(cycle);
		acc_hist.push_back(cycle);
		word = 16'h0000;
		if (in_range(r) && r.we)
			ref_write(word_addr(r), r.wdata, r.be);
		else if (in_range(r))
			word = ref_read(word_addr(r));
		exp_q.push_back(word);
		last_req = r;
		have_req = 1'b1;
	endtask

	// bus monitor sampling what the DUT sees at the edge
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			err_count++;
			report_and_finish();
		end else if (rst_n) begin
			if (!we_n || !oe_n || !bhe_n || !ble_n) begin
				expect_equal(32'(have_req && in_range(last_req)), 32'd1,
					"strobe low, no mapped cmd");
				expect_equal(32'(sram_addr), 32'(word_addr(last_req)), "sram address");
				expect_equal(32'({we_n, oe_n}), last_req.we ? 32'd1 : 32'd2, "strobe direction");
				if (last_req.we) begin
					expect_equal(32'({bhe_n, ble_n}),
						32'({~last_req.be[1], ~last_req.be[0]}), "write byte enables");
					expect_equal(32'(sram_wdata), 32'(last_req.wdata), "sram write data");
				end else begin
					expect_equal(32'({bhe_n, ble_n}), 32'd0, "read byte enables");
				end
			end
			// c1 in Q0 and Q1, c3 in Q1 and Q2, handshake only in Q3
			expect_equal(32'(c1), 32'(slot_phase == 2'd0 || slot_phase == 2'd1), "c1 enable");
			expect_equal(32'(c3), 32'(slot_phase == 2'd1 || slot_phase == 2'd2), "c3 enable");
			expect_equal(32'(req_ready), 32'(req_valid && slot_phase == 2'd3), "req_ready pulse");
			// command back to idle in Q3
			if (slot_phase == 2'd3)
				expect_equal(32'({we_n, oe_n, bhe_n, ble_n}), 32'hf, "strobes idle in Q3");
			slot_phase <= slot_phase + 2'd1;
			if (resp_valid) begin
				responses++;
				last_rdata = rdata;
				if (exp_q.size() == 0) begin
					err_count++;
					$display("response pulse at %t with no request outstanding", $time);
				end else begin
					exp_word = exp_q.pop_front();
					acc_cycle = acc_q.pop_front();
					expect_equal(32'(rdata), 32'(exp_word), "response data");
					expect_equal(cycle - acc_cycle, 32'd4, "response latency in clocks");
				end
			end
			if (req_valid && req_ready)
				accept_request(req);
		end else begin
			slot_phase <= 2'd3;
		end
	end

	// runs from a falling edge to the falling edge after acceptance
	task automatic send(input host_req_t r);
		int target;
		target = accepted + 1;
		req = r;
		req_valid = 1'b1;
		do
			@(negedge clk);
		while (accepted < target);
	endtask

	task automatic drain();
		req_valid = 1'b0;
		while (responses < accepted)
			@(negedge clk);
	endtask

	task automatic check_idle_pins(input string when);
		expect_equal(32'(req_ready), 32'd0, {"req_ready ", when});
		expect_equal(32'(resp_valid), 32'd0, {"resp_valid ", when});
		expect_equal(32'({we_n, oe_n, bhe_n, ble_n}), 32'hf, {"strobes ", when});
	endtask

	task automatic reset_and_check();
		rst_n = 1'b0;
		// a waiting request gets no req_ready while in reset
		req_valid = 1'b1;
		repeat (2) begin
			@(negedge clk);
			check_idle_pins("during reset");
		end
		rst_n = 1'b1;
		req_valid = 1'b0;
		@(negedge clk);
		check_idle_pins("after reset");
	endtask

	task automatic test_word_rw();
		send(make_req(2'b00, 3'd5, 18'h01234, 1'b1, 2'b11, 16'hbeef));
		send(make_req(2'b00, 3'd5, 18'h01234, 1'b0, 2'b00, 16'h0000));
		drain();
		expect_equal(32'(last_rdata), 32'hbeef, "word read back");
	endtask

	task automatic test_byte_lanes();
		send(make_req(2'b00, 3'd2, 18'h00abc, 1'b1, 2'b11, 16'h1122));
		send(make_req(2'b00, 3'd2, 18'h00abc, 1'b1, 2'b10, 16'h33ff));
		send(make_req(2'b00, 3'd2, 18'h00abc, 1'b1, 2'b01, 16'hee44));
		send(make_req(2'b00, 3'd2, 18'h00abc, 1'b0, 2'b00, 16'h0000));
		drain();
		expect_equal(32'(last_rdata), 32'h3344, "merged byte lanes");
	endtask

	task automatic test_out_of_range();
		send(make_req(2'b00, 3'd0, 18'h00777, 1'b1, 2'b11, 16'h5a5a));
		// same offset and bank bits 4 MB higher
		send(make_req(2'b01, 3'd0, 18'h00777, 1'b1, 2'b11, 16'hdead));
		send(make_req(2'b00, 3'd0, 18'h00777, 1'b0, 2'b00, 16'h0000));
		drain();
		expect_equal(32'(last_rdata), 32'h5a5a, "bank 0 after unmapped write");
		send(make_req(2'b11, 3'd6, 18'h00777, 1'b0, 2'b00, 16'h0000));
		drain();
		expect_equal(32'(last_rdata), 32'h0000, "unmapped read");
	endtask

	task automatic test_random();
		host_req_t r;
		int first;
		first = acc_hist.size();
		for (int i = 0; i < RANDOM_REQS; i++) begin
			r = '0;
			r.addr[21:19] = 3'($random(seed));
			// few offsets so reads hit earlier writes
			r.addr[4:1] = 4'($random(seed));
			if (($random(seed) & 7) == 0)
				r.addr[23:22] = 2'($random(seed)) | 2'b01;
			r.wdata = 16'($random(seed));
			r.we = 1'($random(seed));
			r.be = 2'($random(seed));
			send(r);
		end
		drain();
		expect_equal(32'(acc_hist[first + RANDOM_REQS - 1] - acc_hist[first]),
			32'(4 * (RANDOM_REQS - 1)), "acceptance on successive Q3");
		expect_equal(32'(accepted), 32'(responses), "acceptances against responses");
	endtask

	initial begin
		$timeformat(-9, 0, " ns", 0);
		rst_n = 1'b0;
		req_valid = 1'b0;
		req = '0;
		reset_and_check();
		test_word_rw();
		test_byte_lanes();
		test_out_of_range();
		test_random();
		report_and_finish();
	end

endmodule

/* test/sram_bridge_assert.sv */
/*
 * concurrent checks on the SRAM strobes of the bridge
 */

`timescale 1ns/1ps

module sram_bridge_assert (
	input  logic clk,
	input  logic rst_n,
	input  sram_pkg::bus_cmd_t cmd,
	input  logic we_n,
	input  logic oe_n,
	input  logic bhe_n,
	input  logic ble_n
);

	logic strobes_idle;

	assign strobes_idle = we_n && oe_n && bhe_n && ble_n;

	// read and write never overlap
	no_rd_wr_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		!(!we_n && !oe_n))
		else $error("we_n and oe_n low together");

	// no bank, no memory cycle
	idle_without_bank: assert property (@(posedge clk) disable iff (!rst_n)
		(cmd.bank == '0) |-> strobes_idle)
		else $error("strobe low while no bank is selected");

	// first clock out of reset
	idle_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> strobes_idle)
		else $error("strobe low in the clock after reset");

endmodule

/* test/sram_model.sv */
/*
 * behavioral asynchronous 16-bit SRAM, 2M words
 * byte lanes, write committed on the rising edge of we_n
 */

`timescale 1ns/1ps

module sram_model (
	input  logic [20:0] addr,
	input  logic [15:0] wdata,
	output logic [15:0] rdata,
	input  logic we_n,
	input  logic oe_n,
	input  logic bhe_n,
	input  logic ble_n
);

	// sparse storage, only written words exist
	logic [15:0] mem[int];
	logic [20:0] wr_addr = '0;
	logic [15:0] wr_data = '0;
	logic wr_hi = 1'b0;
	logic wr_lo = 1'b0;

	function automatic logic [15:0] read_word(input logic [20:0] a);
		if (mem.exists(int'(a)))
			return mem[int'(a)];
		// power-up content, a pattern over the whole address
		return a[15:0] ^ {11'h000, a[20:16]} ^ 16'h6b1d;
	endfunction

	// pins settle after the strobe falls, latch them mid-pulse
	always @(negedge we_n) begin
		#1;
		wr_addr = addr;
		wr_data = wdata;
		wr_hi = !bhe_n;
		wr_lo = !ble_n;
	end

	// commit at the end of the write pulse
	always @(posedge we_n) begin
		logic [15:0] w;
		w = read_word(wr_addr);
		if (wr_hi)
			w[15:8] = wr_data[15:8];
		if (wr_lo)
			w[7:0] = wr_data[7:0];
		if (wr_hi || wr_lo)
			mem[int'(wr_addr)] = w;
	end

	// split bus, lanes driven only while selected
	always @(addr or oe_n or bhe_n or ble_n) begin
		logic [15:0] w;
		w = read_word(addr);
		rdata = 16'h0000;
		if (!oe_n && !bhe_n)
			rdata[15:8] = w[15:8];
		if (!oe_n && !ble_n)
			rdata[7:0] = w[7:0];
	end

endmodule

/* rtl/sram_subsys_top.sv */
/*
 * SRAM subsystem top level
 * phase timer, bus cycle FSM and SRAM bridge wired together
 */

`timescale 1ns/1ps

module sram_subsys_top (
	input  logic clk,
	input  logic rst_n,
	// host port
	input  logic req_valid,
	input  sram_pkg::host_req_t req,
	output logic req_ready,
	output logic resp_valid,
	output logic [15:0] rdata,
	// slot enables for the rest of the chipset
	output logic c1,
	output logic c3,
	// SRAM pins
	output logic bhe_n,
	output logic ble_n,
	output logic we_n,
	output logic oe_n,
	output logic [sram_pkg::SRAM_ADDR_BITS-1:0] sram_addr,
	output logic [15:0] sram_wdata,
	input  logic [15:0] sram_rdata
);

	import sram_pkg::*;

	phase_t phase;
	bus_cmd_t cmd;
	// bridge read mux back to the FSM
	logic [15:0] data_out;

	bus_phase_timer bus_phase_timer_inst (
		.clk(clk),
		.rst_n(rst_n),
		.phase(phase),
		.c1(c1),
		.c3(c3)
	);

	bus_cycle_fsm bus_cycle_fsm_inst (
		.clk(clk),
		.rst_n(rst_n),
		.phase(phase),
		.req_valid(req_valid),
		.req(req),
		.req_ready(req_ready),
		.cmd(cmd),
		.data_out(data_out),
		.resp_valid(resp_valid),
		.rdata(rdata)
	);

	sram_bridge sram_bridge_inst (
		.cmd(cmd),
		.data_out(data_out),
		.bhe_n(bhe_n),
		.ble_n(ble_n),
		.we_n(we_n),
		.oe_n(oe_n),
		.sram_addr(sram_addr),
		.sram_wdata(sram_wdata),
		.sram_rdata(sram_rdata)
	);

endmodule

/* rtl/sram_bridge.sv */
/*
 * chipset bus to asynchronous SRAM bridge
 * active-low strobes, bank-encoded SRAM address, read data mux
 */

`timescale 1ns/1ps

module sram_bridge (
	input  sram_pkg::bus_cmd_t cmd,
	output logic [15:0] data_out,
	output logic bhe_n,
	output logic ble_n,
	output logic we_n,
	output logic oe_n,
	output logic [sram_pkg::SRAM_ADDR_BITS-1:0] sram_addr,
	output logic [15:0] sram_wdata,
	input  logic [15:0] sram_rdata
);

	import sram_pkg::*;

	// any bank selected means a real memory cycle
	logic enable;
	logic wr;
	logic [BANK_SEL_BITS-1:0] bank_enc;

	assign enable = |cmd.bank;
	assign wr = cmd.hwr || cmd.lwr;

	// write strobe for the whole command, rises when cmd goes idle in Q3
	assign we_n = !(enable && wr);
	assign oe_n = !(enable && cmd.rd);

	// reads open both lanes
	// writes use the per-byte bits
	assign bhe_n = !(enable && (cmd.rd || cmd.hwr));
	assign ble_n = !(enable && (cmd.rd || cmd.lwr));

	// one-hot to binary for the upper address bits
	// bit 2 = banks 4..7, bit 1 = banks 2,3,6,7, bit 0 = odd banks
	always_comb begin
		bank_enc = '0;
		for (int i = 0; i < BANK_COUNT; i++) begin
			if (cmd.bank[i])
				bank_enc = bank_enc | BANK_SEL_BITS'(i);
		end
	end

	assign sram_addr = {bank_enc, cmd.address_in};

	// split bus, data always driven toward the SRAM
	assign sram_wdata = cmd.data_in;

	// read mux, zero outside an enabled read
	assign data_out = (enable && cmd.rd) ? sram_rdata : 16'h0000;

endmodule

/* rtl/bus_cycle_fsm.sv */
/*
 * bus cycle state machine
 * host request acceptance in Q3, one-hot bank decode,
 * registered bus command, read data capture and response pulse
 */

`timescale 1ns/1ps

module bus_cycle_fsm (
	input  logic clk,
	input  logic rst_n,
	input  sram_pkg::phase_t phase,
	input  logic req_valid,
	input  sram_pkg::host_req_t req,
	output logic req_ready,
	output sram_pkg::bus_cmd_t cmd,
	input  logic [15:0] data_out,
	output logic resp_valid,
	output logic [15:0] rdata
);

	import sram_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACTIVE,
		ST_RESPOND
	} state_t;

	state_t state;

	// control part of the command
	logic [BANK_COUNT-1:0] bank_q;
	logic rd_q;
	logic hwr_q;
	logic lwr_q;

	// payload part held over Q3 so the write data outlives we_n
	logic [BANK_ADDR_BITS:1] offset_q;
	logic [15:0] wdata_q;

	logic accept;
	logic in_range;
	logic [BANK_SEL_BITS-1:0] bank_idx;
	logic [BANK_COUNT-1:0] bank_dec;

	// one slot per request taken only in Q3
	// the timer sits in Q3 during reset, so reset masks the handshake
	assign req_ready = rst_n && req_valid && (phase == Q3);
	assign accept = req_ready;

	// bits 23:22 zero means below 4 MB
	assign in_range = (req.addr[ADDR_MSB:BANK_ADDR_BITS+BANK_SEL_BITS+1] == '0);
	// bits 21:19 pick one of the eight banks
	assign bank_idx = req.addr[BANK_ADDR_BITS+BANK_SEL_BITS:BANK_ADDR_BITS+1];

	always_comb begin
		bank_dec = '0;
		// out of range leaves every bank off
		if (in_range)
			bank_dec[bank_idx] = 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			bank_q <= '0;
			rd_q <= 1'b0;
			hwr_q <= 1'b0;
			lwr_q <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (accept) begin
						state <= ST_ACTIVE;
						bank_q <= bank_dec;
						rd_q <= !req.we;
						hwr_q <= req.we && req.be[1];
						lwr_q <= req.we && req.be[0];
					end
				end
				ST_ACTIVE: begin
					// command lives Q0..Q2 and goes idle in Q3
					if (phase == Q2) begin
						state <= ST_RESPOND;
						bank_q <= '0;
						rd_q <= 1'b0;
						hwr_q <= 1'b0;
						lwr_q <= 1'b0;
					end
				end
				ST_RESPOND: begin
					// back-to-back request overlaps the response
					if (accept) begin
						state <= ST_ACTIVE;
						bank_q <= bank_dec;
						rd_q <= !req.we;
						hwr_q <= req.we && req.be[1];
						lwr_q <= req.we && req.be[0];
					end else begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// offset and write data only move on acceptance
	always_ff @(posedge clk) begin
		if (accept) begin
			offset_q <= req.addr[BANK_ADDR_BITS:1];
			wdata_q <= req.wdata;
		end
	end

	// sample the bridge mux at the edge that ends Q2
	// writes and unmapped reads see zero here
	always_ff @(posedge clk) begin
		if ((state == ST_ACTIVE) && (phase == Q2))
			rdata <= data_out;
	end

	// single Q3 clock without back-pressure
	assign resp_valid = (state == ST_RESPOND);

	assign cmd = '{
		bank: bank_q,
		address_in: offset_q,
		data_in: wdata_q,
		rd: rd_q,
		hwr: hwr_q,
		lwr: lwr_q
	};

endmodule

/* rtl/bus_phase_timer.sv */
/*
 * bus slot phase timer
 * free-running Q0..Q3 counter with registered c1/c3 enables
 */

`timescale 1ns/1ps

module bus_phase_timer (
	input  logic clk,
	input  logic rst_n,
	output sram_pkg::phase_t phase,
	output logic c1,
	output logic c3
);

	import sram_pkg::*;

	phase_t phase_q;
	phase_t phase_next;

	// wraps from Q3 back to Q0 on its own
	assign phase_next = phase_t'(phase_q + 2'd1);

	// reset to Q3 so Q0 comes with the first clock
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase_q <= Q3;
			c1 <= 1'b0;
			c3 <= 1'b0;
		end else begin
			phase_q <= phase_next;
			// c1 high in Q0 and Q1
			c1 <= (phase_next == Q0) || (phase_next == Q1);
			// c3 high in Q1 and Q2, a quarter slot after c1
			c3 <= (phase_next == Q1) || (phase_next == Q2);
		end
	end

	assign phase = phase_q;

endmodule

/* rtl/sram_pkg.sv */
/*
 * shared definitions for the SRAM subsystem
 * bank geometry localparams, slot phase type,
 * host request struct and chipset bus command struct
 */

package sram_pkg;

	// eight banks of 512 KB each
	localparam int BANK_COUNT = 8;
	localparam int BANK_SEL_BITS = $clog2(BANK_COUNT);
	// word offset inside one bank, byte address bits 18:1
	localparam int BANK_ADDR_BITS = 18;
	// 21-bit word address on the SRAM pins
	localparam int SRAM_ADDR_BITS = BANK_SEL_BITS + BANK_ADDR_BITS;
	// top bit of the host byte address
	localparam int ADDR_MSB = 23;

	// four phases of the bus slot, one system clock each
	typedef enum logic [1:0] {
		Q0 = 2'd0,
		Q1 = 2'd1,
		Q2 = 2'd2,
		Q3 = 2'd3
	} phase_t;

	// host request, 42 bits
	typedef struct packed {
		// byte address without bit 0
		logic [ADDR_MSB:1] addr;
		logic [15:0] wdata;
		// high for write
		logic we;
		// {upper, lower} byte enable
		logic [1:0] be;
	} host_req_t;

	// registered chipset bus command, 45 bits
	typedef struct packed {
		// one-hot bank select, zero means no access
		logic [BANK_COUNT-1:0] bank;
		logic [BANK_ADDR_BITS:1] address_in;
		logic [15:0] data_in;
		logic rd;
		// high and low byte write
		logic hwr;
		logic lwr;
	} bus_cmd_t;

endpackage
